/* Bender.yml */
package:
  name: glb_cfg_chain

sources:
  - glb_pkg.sv
  - glb_cfg_bank.sv
  - glb_sram_cfg_ctrl.sv
  - glb_tile.sv
  - glb_cfg_chain.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_glb_cfg_chain.sv

/* compile.f */
+incdir+.
glb_pkg.sv
glb_cfg_bank.sv
glb_sram_cfg_ctrl.sv
glb_tile.sv
glb_cfg_chain.sv
tb_glb_cfg_chain.sv

/* glb_cfg_bank.sv */
/* Behavioral config SRAM bank with a fixed two-cycle read latency.
   No byte enables and no read-during-write bypass; a same-edge read sees old data. */
`timescale 1ns/1ps

module glb_cfg_bank (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr_en,
    input  logic                wr_clk_en,
    input  glb_pkg::bank_addr_t wr_addr,
    input  glb_pkg::cfg_data_t  wr_data,
    input  logic                rd_en,
    input  logic                rd_clk_en,
    input  glb_pkg::bank_addr_t rd_addr,
    output glb_pkg::cfg_data_t  rd_data,
    output logic                rd_data_valid
);

    glb_pkg::cfg_data_t mem [glb_pkg::bank_depth];

    logic               rd_accept;
    logic               rd_valid_d1;   // Read stage valid
    glb_pkg::cfg_data_t rd_data_d1;    // Read stage data

    assign rd_accept = rd_en & rd_clk_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Array and data pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (wr_en && wr_clk_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_accept) begin
            rd_data_d1 <= mem[rd_addr];
        end
        if (rd_valid_d1) begin
            rd_data <= rd_data_d1;   // Holds last word between reads
        end
    end

    // Valid pipeline
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_d1   <= 1'b0;
            rd_data_valid <= 1'b0;
        end else begin
            rd_valid_d1   <= rd_accept;
            rd_data_valid <= rd_valid_d1;
        end
    end

    // Every valid pulse comes from a read accepted exactly two edges back
    a_valid_after_read : assert property (
        @(posedge clk) disable iff (reset)
        rd_data_valid |-> $past(rd_en && rd_clk_en, glb_pkg::bank_rd_latency)
    ) else $error("Bank valid without an accepted read two cycles earlier");

endmodule

/* glb_cfg_chain.sv */
/* Config chain top: tiles linked west to east, host on the west of tile 0.
   Host must keep read return slots distinct; colliding returns lose the eastern data. */
`timescale 1ns/1ps

module glb_cfg_chain (
    input  logic               clk,
    input  logic               reset,

    // Host port, west side of tile 0
    input  logic               wr_en,
    input  logic               wr_clk_en,
    input  glb_pkg::cfg_addr_t wr_addr,
    input  glb_pkg::cfg_data_t wr_data,
    input  logic               rd_en,
    input  logic               rd_clk_en,
    input  glb_pkg::cfg_addr_t rd_addr,
    output glb_pkg::cfg_data_t rd_data,
    output logic               rd_data_valid
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Links, index k is the west side of tile k
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int num_links = glb_pkg::num_tiles + 1;

    logic               lnk_wr_en        [num_links];
    logic               lnk_wr_clk_en    [num_links];
    glb_pkg::cfg_addr_t lnk_wr_addr      [num_links];
    glb_pkg::cfg_data_t lnk_wr_data      [num_links];
    logic               lnk_rd_en        [num_links];
    logic               lnk_rd_clk_en    [num_links];
    glb_pkg::cfg_addr_t lnk_rd_addr      [num_links];
    glb_pkg::cfg_data_t lnk_rd_data      [num_links];
    logic               lnk_rd_data_valid[num_links];

    assign lnk_wr_en[0]     = wr_en;
    assign lnk_wr_clk_en[0] = wr_clk_en;
    assign lnk_wr_addr[0]   = wr_addr;
    assign lnk_wr_data[0]   = wr_data;
    assign lnk_rd_en[0]     = rd_en;
    assign lnk_rd_clk_en[0] = rd_clk_en;
    assign lnk_rd_addr[0]   = rd_addr;
    assign rd_data          = lnk_rd_data[0];
    assign rd_data_valid    = lnk_rd_data_valid[0];

    // Nothing returns from beyond the east end
    assign lnk_rd_data[glb_pkg::num_tiles]       = '0;
    assign lnk_rd_data_valid[glb_pkg::num_tiles] = 1'b0;

    for (genvar t = 0; t < glb_pkg::num_tiles; t++) begin : g_tile
        glb_tile #(
            .tile_id (glb_pkg::tile_id_t'(t))
        ) tile_i (
            .clk               (clk),
            .reset             (reset),
            .wst_wr_en         (lnk_wr_en[t]),
            .wst_wr_clk_en     (lnk_wr_clk_en[t]),
            .wst_wr_addr       (lnk_wr_addr[t]),
            .wst_wr_data       (lnk_wr_data[t]),
            .wst_rd_en         (lnk_rd_en[t]),
            .wst_rd_clk_en     (lnk_rd_clk_en[t]),
            .wst_rd_addr       (lnk_rd_addr[t]),
            .wst_rd_data       (lnk_rd_data[t]),
            .wst_rd_data_valid (lnk_rd_data_valid[t]),
            .est_wr_en         (lnk_wr_en[t+1]),   // Last link's requests fall off the end
            .est_wr_clk_en     (lnk_wr_clk_en[t+1]),
            .est_wr_addr       (lnk_wr_addr[t+1]),
            .est_wr_data       (lnk_wr_data[t+1]),
            .est_rd_en         (lnk_rd_en[t+1]),
            .est_rd_clk_en     (lnk_rd_clk_en[t+1]),
            .est_rd_addr       (lnk_rd_addr[t+1]),
            .est_rd_data       (lnk_rd_data[t+1]),
            .est_rd_data_valid (lnk_rd_data_valid[t+1])
        );
    end

endmodule

/* glb_pkg.sv */
/* Address layout: word field in the low bits, bank field above it, tile field on top.
   The tile field encodes more values than num_tiles, so the top values answer nobody. */
package glb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int cfg_data_width      = 32;
    localparam int bank_addr_width     = 6;   // 64 words per bank
    localparam int banks_per_tile      = 2;
    localparam int bank_sel_addr_width = 1;
    localparam int tile_sel_addr_width = 2;
    localparam int num_tiles           = 3;
    localparam int cfg_addr_width      = bank_addr_width + bank_sel_addr_width
                                         + tile_sel_addr_width;

    localparam int bank_depth      = 1 << bank_addr_width;
    localparam int bank_rd_latency = 2;   // Accepted read to valid, in cycles

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field positions inside cfg_addr_t
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int bank_sel_lsb = bank_addr_width;
    localparam int tile_sel_lsb = bank_addr_width + bank_sel_addr_width;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [cfg_data_width-1:0]      cfg_data_t;
    typedef logic [cfg_addr_width-1:0]      cfg_addr_t;
    typedef logic [bank_addr_width-1:0]     bank_addr_t;
    typedef logic [tile_sel_addr_width-1:0] tile_id_t;   // Type of the tile parameter

endpackage

/* glb_sram_cfg_ctrl.sv */
/* Per-tile config controller with bank decode, one-stage east forward and registered west return.
   No flow control; a local read return overrides any east data landing in the same slot. */
`timescale 1ns/1ps

module glb_sram_cfg_ctrl #(
    parameter glb_pkg::tile_id_t tile_id = '0
) (
    input  logic                clk,
    input  logic                reset,

    // West requests in, west return out
    input  logic                wst_wr_en,
    input  logic                wst_wr_clk_en,
    input  glb_pkg::cfg_addr_t  wst_wr_addr,
    input  glb_pkg::cfg_data_t  wst_wr_data,
    input  logic                wst_rd_en,
    input  logic                wst_rd_clk_en,
    input  glb_pkg::cfg_addr_t  wst_rd_addr,
    output glb_pkg::cfg_data_t  wst_rd_data,
    output logic                wst_rd_data_valid,

    // East requests out, east return in
    output logic                est_wr_en,
    output logic                est_wr_clk_en,
    output glb_pkg::cfg_addr_t  est_wr_addr,
    output glb_pkg::cfg_data_t  est_wr_data,
    output logic                est_rd_en,
    output logic                est_rd_clk_en,
    output glb_pkg::cfg_addr_t  est_rd_addr,
    input  glb_pkg::cfg_data_t  est_rd_data,
    input  logic                est_rd_data_valid,

    // Bank side
    output logic [glb_pkg::banks_per_tile-1:0] bank_wr_en,
    output logic [glb_pkg::banks_per_tile-1:0] bank_rd_en,
    output logic                bank_wr_clk_en,
    output logic                bank_rd_clk_en,
    output glb_pkg::bank_addr_t bank_wr_addr,
    output glb_pkg::cfg_data_t  bank_wr_data,
    output glb_pkg::bank_addr_t bank_rd_addr,
    input  glb_pkg::cfg_data_t  bank_rd_data [glb_pkg::banks_per_tile],
    input  logic                bank_rd_data_valid [glb_pkg::banks_per_tile]
);

    logic               wr_tile_hit;
    logic               rd_tile_hit;
    logic [glb_pkg::banks_per_tile-1:0] rd_hit;      // Accepted local reads
    logic [glb_pkg::banks_per_tile-1:0] rd_hit_d1;
    logic [glb_pkg::banks_per_tile-1:0] rd_hit_d2;   // Bank data valid this cycle
    glb_pkg::cfg_data_t rd_data_next;
    logic               rd_data_valid_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Local decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign wr_tile_hit = (wst_wr_addr[glb_pkg::tile_sel_lsb +: glb_pkg::tile_sel_addr_width]
                          == tile_id);
    assign rd_tile_hit = (wst_rd_addr[glb_pkg::tile_sel_lsb +: glb_pkg::tile_sel_addr_width]
                          == tile_id);

    for (genvar i = 0; i < glb_pkg::banks_per_tile; i++) begin : g_decode
        assign bank_wr_en[i] = wst_wr_en & wr_tile_hit
            & (wst_wr_addr[glb_pkg::bank_sel_lsb +: glb_pkg::bank_sel_addr_width]
               == glb_pkg::bank_sel_addr_width'(i));
        assign bank_rd_en[i] = wst_rd_en & rd_tile_hit
            & (wst_rd_addr[glb_pkg::bank_sel_lsb +: glb_pkg::bank_sel_addr_width]
               == glb_pkg::bank_sel_addr_width'(i));
        assign rd_hit[i] = bank_rd_en[i] & wst_rd_clk_en;   // Gated reads return nothing
    end

    // Shared bank signals straight from the west
    assign bank_wr_clk_en = wst_wr_clk_en;
    assign bank_rd_clk_en = wst_rd_clk_en;
    assign bank_wr_addr   = wst_wr_addr[glb_pkg::bank_addr_width-1:0];
    assign bank_wr_data   = wst_wr_data;
    assign bank_rd_addr   = wst_rd_addr[glb_pkg::bank_addr_width-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Return merge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rd_data_next       = est_rd_data;
        rd_data_valid_next = est_rd_data_valid;
        for (int i = 0; i < glb_pkg::banks_per_tile; i++) begin
            if (rd_hit_d2[i]) begin   // Local data wins the slot
                rd_data_next       = bank_rd_data[i];
                rd_data_valid_next = bank_rd_data_valid[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_hit_d1         <= '0;
            rd_hit_d2         <= '0;
            wst_rd_data       <= '0;
            wst_rd_data_valid <= 1'b0;
            est_wr_en         <= 1'b0;
            est_wr_clk_en     <= 1'b0;
            est_wr_addr       <= '0;
            est_wr_data       <= '0;
            est_rd_en         <= 1'b0;
            est_rd_clk_en     <= 1'b0;
            est_rd_addr       <= '0;
        end else begin
            rd_hit_d1         <= rd_hit;
            rd_hit_d2         <= rd_hit_d1;
            wst_rd_data       <= rd_data_next;
            wst_rd_data_valid <= rd_data_valid_next;
            // Forward everything east, one stage
            est_wr_en         <= wst_wr_en;
            est_wr_clk_en     <= wst_wr_clk_en;
            est_wr_addr       <= wst_wr_addr;
            est_wr_data       <= wst_wr_data;
            est_rd_en         <= wst_rd_en;
            est_rd_clk_en     <= wst_rd_clk_en;
            est_rd_addr       <= wst_rd_addr;
        end
    end

    // Field decode admits one bank per request, so one slot owner at most
    a_one_slot_owner : assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(rd_hit_d2)
    ) else $error("Tile %0d: more than one bank owns a return slot", tile_id);

endmodule

/* glb_tile.sv */
/* One buffer tile: config controller plus its banks.
   Config path only; streaming paths of the buffer are not modelled here. */
`timescale 1ns/1ps

module glb_tile #(
    parameter glb_pkg::tile_id_t tile_id = '0
) (
    input  logic               clk,
    input  logic               reset,

    input  logic               wst_wr_en,
    input  logic               wst_wr_clk_en,
    input  glb_pkg::cfg_addr_t wst_wr_addr,
    input  glb_pkg::cfg_data_t wst_wr_data,
    input  logic               wst_rd_en,
    input  logic               wst_rd_clk_en,
    input  glb_pkg::cfg_addr_t wst_rd_addr,
    output glb_pkg::cfg_data_t wst_rd_data,
    output logic               wst_rd_data_valid,

    output logic               est_wr_en,
    output logic               est_wr_clk_en,
    output glb_pkg::cfg_addr_t est_wr_addr,
    output glb_pkg::cfg_data_t est_wr_data,
    output logic               est_rd_en,
    output logic               est_rd_clk_en,
    output glb_pkg::cfg_addr_t est_rd_addr,
    input  glb_pkg::cfg_data_t est_rd_data,
    input  logic               est_rd_data_valid
);

    // Controller to bank wiring
    logic [glb_pkg::banks_per_tile-1:0] bank_wr_en;
    logic [glb_pkg::banks_per_tile-1:0] bank_rd_en;
    logic                bank_wr_clk_en;
    logic                bank_rd_clk_en;
    glb_pkg::bank_addr_t bank_wr_addr;
    glb_pkg::cfg_data_t  bank_wr_data;
    glb_pkg::bank_addr_t bank_rd_addr;
    glb_pkg::cfg_data_t  bank_rd_data [glb_pkg::banks_per_tile];
    logic                bank_rd_data_valid [glb_pkg::banks_per_tile];

    glb_sram_cfg_ctrl #(
        .tile_id (tile_id)
    ) cfg_ctrl_i (
        .*
    );

    for (genvar b = 0; b < glb_pkg::banks_per_tile; b++) begin : g_bank
        glb_cfg_bank bank_i (
            .clk           (clk),
            .reset         (reset),
            .wr_en         (bank_wr_en[b]),
            .wr_clk_en     (bank_wr_clk_en),   // Clock enables shared by all banks
            .wr_addr       (bank_wr_addr),
            .wr_data       (bank_wr_data),
            .rd_en         (bank_rd_en[b]),
            .rd_clk_en     (bank_rd_clk_en),
            .rd_addr       (bank_rd_addr),
            .rd_data       (bank_rd_data[b]),
            .rd_data_valid (bank_rd_data_valid[b])
        );
    end

endmodule

/* tb_glb_cfg_tasks.svh */
/* Stimulus tasks and tests, included in the testbench module body.
   All DUT inputs change on the falling clock edge only. */
`ifndef TB_GLB_CFG_TASKS_SVH
`define TB_GLB_CFG_TASKS_SVH

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] val;
        logic        out_bit;
        val = '0;
        for (int i = 0; i < n; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            val = {val[30:0], out_bit};
        end
        return val;
    endfunction

    function automatic int tile_of(glb_pkg::cfg_addr_t addr);
        return int'(addr >> glb_pkg::tile_sel_lsb);
    endfunction

    // Two bank cycles, one return register per tile, one forward stage per tile
    function automatic int return_latency(glb_pkg::cfg_addr_t addr);
        return 2 * tile_of(addr) + 3;
    endfunction

    function automatic glb_pkg::cfg_addr_t addr_in_tile(int tile);
        return glb_pkg::cfg_addr_t'((tile << glb_pkg::tile_sel_lsb)
                                    | rand_bits(glb_pkg::tile_sel_lsb));
    endfunction

    function automatic bit slot_free(int slot);
        foreach (exp_cycle_q[i]) begin
            if (exp_cycle_q[i] == slot) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic void refresh_head();
        head_valid = (exp_cycle_q.size() != 0);
        if (head_valid) begin
            head_cycle = exp_cycle_q[0];
            head_data  = exp_data_q[0];
        end
    endfunction

    function automatic void push_expected(int slot, glb_pkg::cfg_data_t data);
        int pos;
        pos = exp_cycle_q.size();
        for (int i = 0; i < exp_cycle_q.size(); i++) begin
            if (exp_cycle_q[i] > slot) begin
                pos = i;
                break;
            end
        end
        exp_cycle_q.insert(pos, slot);
        exp_data_q.insert(pos, data);
        refresh_head();
    endfunction

    function automatic void clear_inputs();
        wr_en     = 1'b0;
        wr_clk_en = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        rd_en     = 1'b0;
        rd_clk_en = 1'b0;
        rd_addr   = '0;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus cycles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    task automatic write_word(glb_pkg::cfg_addr_t addr, glb_pkg::cfg_data_t data,
                              logic en, logic clk_en);
        @(negedge clk);
        clear_inputs();
        wr_en     = en;
        wr_clk_en = clk_en;
        wr_addr   = addr;
        wr_data   = data;
        if (en && clk_en && tile_of(addr) < glb_pkg::num_tiles) begin
            ref_mem[addr] = data;
        end
    endtask

    task automatic read_word(glb_pkg::cfg_addr_t addr, logic clk_en);
        bit booked;
        @(negedge clk);
        clear_inputs();
        booked = clk_en && (tile_of(addr) < glb_pkg::num_tiles);
        while (booked && !slot_free(cycle + return_latency(addr))) begin
            @(negedge clk);   // Slot taken, hold off a cycle
        end
        rd_en       = 1'b1;
        rd_clk_en   = clk_en;
        rd_addr     = addr;
        read_issued = 1'b1;
        if (booked) begin
            push_expected(cycle + return_latency(addr), ref_mem[addr]);
        end
    endtask

    task automatic start_test(string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        idle(1);
        while (exp_cycle_q.size() != 0) begin
            @(negedge clk);
        end
        idle(max_latency);   // Window for stray valids
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("Test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", test_name,
                     error_count - errors_at_start);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_idle_after_reset();
        start_test("idle_after_reset");
        idle(20);
        finish_test();
    endtask

    task automatic write_read_all();
        start_test("write_read_all");
        for (int a = 0; a < chain_words; a++) begin
            write_word(glb_pkg::cfg_addr_t'(a), rand_bits(32), 1'b1, 1'b1);
        end
        for (int a = 0; a < chain_words; a++) begin
            read_word(glb_pkg::cfg_addr_t'(a), 1'b1);
        end
        finish_test();
    endtask

    task automatic gated_access();
        glb_pkg::cfg_addr_t addr;
        start_test("gated_access");
        for (int t = 0; t < glb_pkg::num_tiles; t++) begin
            addr = addr_in_tile(t);
            write_word(addr, rand_bits(32), 1'b1, 1'b0);   // Clock enable low
            write_word(addr, rand_bits(32), 1'b0, 1'b1);   // Write enable low
            read_word(addr, 1'b0);                         // Must give no valid
            idle(max_latency);
            read_word(addr, 1'b1);                         // Old word still there
        end
        finish_test();
    endtask

    task automatic unmapped_tile();
        start_test("unmapped_tile");
        for (int i = 0; i < 4; i++) begin
            read_word(addr_in_tile(glb_pkg::num_tiles), 1'b1);
        end
        idle(max_latency);
        finish_test();
    endtask

    task automatic back_to_back_reads();
        start_test("back_to_back_reads");
        for (int t = 0; t < glb_pkg::num_tiles; t++) begin
            for (int i = 0; i < burst_len; i++) begin
                read_word(glb_pkg::cfg_addr_t'((t << glb_pkg::tile_sel_lsb)
                                               | (1 << glb_pkg::bank_sel_lsb) | i), 1'b1);
            end
        end
        finish_test();
    endtask

    // Random tiles, tile 3 included, with writes mixed in
    task automatic mixed_tile_reads();
        glb_pkg::cfg_addr_t addr;
        start_test("mixed_tile_reads");
        for (int i = 0; i < mixed_reads; i++) begin
            if (rand_bits(1) == 1) begin
                write_word(glb_pkg::cfg_addr_t'(rand_bits(glb_pkg::cfg_addr_width)),
                           rand_bits(32), 1'b1, 1'b1);
            end
            addr = glb_pkg::cfg_addr_t'(rand_bits(glb_pkg::cfg_addr_width));
            read_word(addr, 1'b1);
        end
        finish_test();
    endtask

`endif

/* tb_glb_cfg_chain.sv */
/* Testbench for the config chain; the assertions below do all checking.
   Reads wait for a free return slot, so two returns never land in the same cycle. */
`timescale 1ns/1ps

module tb_glb_cfg_chain;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes and run budget
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int mem_words    = 1 << glb_pkg::cfg_addr_width;
    localparam int chain_words  = glb_pkg::num_tiles * glb_pkg::banks_per_tile
                                  * glb_pkg::bank_depth;
    localparam int max_latency  = 2 * glb_pkg::num_tiles + 3;   // Farthest tile round trip
    localparam int burst_len    = 16;
    localparam int mixed_reads  = 48;
    localparam int finish_len   = 1 + 2 * max_latency;          // Drain plus quiet window

    localparam int cycle_limit = reset_cycles
                                 + 20                                      // Idle check
                                 + 2 * chain_words                         // Fill and read back
                                 + glb_pkg::num_tiles * (4 + max_latency)  // Gated access
                                 + 4 + max_latency                         // Unmapped tile
                                 + glb_pkg::num_tiles * burst_len          // Bursts
                                 + mixed_reads * (2 + 2 * max_latency)     // Mixed traffic
                                 + 6 * finish_len
                                 + 100;                                    // Margin

    // DUT ports
    logic               clk;
    logic               reset;
    logic               wr_en;
    logic               wr_clk_en;
    glb_pkg::cfg_addr_t wr_addr;
    glb_pkg::cfg_data_t wr_data;
    logic               rd_en;
    logic               rd_clk_en;
    glb_pkg::cfg_addr_t rd_addr;
    glb_pkg::cfg_data_t rd_data;
    logic               rd_data_valid;

    // Reference memory and expected returns, sorted by slot
    glb_pkg::cfg_data_t ref_mem [mem_words];
    int                 exp_cycle_q [$];
    glb_pkg::cfg_data_t exp_data_q [$];
    logic               head_valid;
    int                 head_cycle;
    glb_pkg::cfg_data_t head_data;
    logic               read_issued;    // Set by the first read of the run

    int          cycle = 0;
    int          error_count = 0;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    string       test_name;
    logic [31:0] lfsr_state;

    `include "tb_glb_cfg_tasks.svh"

    glb_cfg_chain dut_i (.*);

    always #(clk_period / 2) clk = ~clk;

    // Cycle count and watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Retire expected returns once their slot has passed
    always @(negedge clk) begin
        while (head_valid && head_cycle < cycle) begin
            void'(exp_cycle_q.pop_front());
            void'(exp_data_q.pop_front());
            refresh_head();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_quiet_before_read : assert property (
        @(posedge clk) disable iff (reset)
        !read_issued |-> (rd_data == '0 && !rd_data_valid)
    ) else begin
        error_count++;
        $display("Mismatch in test %s: expected data 0 valid 0, actual data %h valid %b",
                 test_name, $sampled(rd_data), $sampled(rd_data_valid));
    end

    a_valid_expected : assert property (
        @(posedge clk) disable iff (reset)
        rd_data_valid |-> (head_valid && head_cycle == cycle)
    ) else begin
        error_count++;
        $display("Test %s: read valid at cycle %0d that no read asked for",
                 test_name, $sampled(cycle));
    end

    a_return_arrives : assert property (
        @(posedge clk) disable iff (reset)
        (head_valid && head_cycle == cycle) |-> rd_data_valid
    ) else begin
        error_count++;
        $display("Test %s: read return due at cycle %0d did not arrive",
                 test_name, $sampled(cycle));
    end

    a_data_match : assert property (
        @(posedge clk) disable iff (reset)
        (rd_data_valid && head_valid && head_cycle == cycle) |-> (rd_data == head_data)
    ) else begin
        error_count++;
        $display("Mismatch in test %s: expected %h, actual %h",
                 test_name, $sampled(head_data), $sampled(rd_data));
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        head_valid   = 1'b0;
        head_cycle   = 0;
        head_data    = '0;
        read_issued  = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        lfsr_state   = 32'hbb24;
        clear_inputs();

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_idle_after_reset();
        write_read_all();
        gated_access();
        unmapped_tile();
        back_to_back_reads();
        mixed_tile_reads();

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
